//--- hw/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Command operation, carried in the MSB of every frame.
  typedef enum logic {
    spi_op_read  = 1'b0,
    spi_op_write = 1'b1
  } spi_op_e;

  typedef logic [2:0] spi_addr_t;
  typedef logic [7:0] spi_data_t;
  typedef logic [3:0] spi_div_t;

  // Field order matches the wire order, MSB first.
  typedef struct packed {
    spi_op_e   op;
    spi_addr_t addr;
    spi_data_t data;
  } spi_cmd_t;

  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // Frame lengths in sclk periods.
  localparam int CMD_BITS        = 12;
  localparam int ADDR_PHASE_BITS = 4;
  localparam int DATA_BITS       = $bits(spi_data_t);

  // Chip select high time between the two halves of a read, in clk cycles.
  localparam int TURNAROUND_CYCLES = 16;

  localparam spi_div_t DIV_RESET = 4'd4;

endpackage

`default_nettype wire

//--- hw/apb_pkg.sv
`default_nettype none

package apb_pkg;

  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 32;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Register map of the SPI controller.
  typedef enum logic [APB_ADDR_W-1:0] {
    REG_CMD    = 4'h0,
    REG_STATUS = 4'h4,
    REG_RXDATA = 4'h8,
    REG_DIV    = 4'hC
  } apb_reg_e;

endpackage

`default_nettype wire

//--- hw/spi_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sclk_en,
  input  spi_pkg::spi_div_t div,
  output logic              sclk_level,
  output logic              sclk_rise,
  output logic              sclk_fall
);

  import spi_pkg::*;

  spi_div_t half_cnt;
  logic     level_q;
  logic     tick;

  // Last clk cycle of the current half-period.
  assign tick = sclk_en && (half_cnt == div);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      level_q  <= 1'b0;
    end
    else if (!sclk_en)
    begin
      half_cnt <= '0;
      level_q  <= 1'b0;
    end
    else if (tick)
    begin
      half_cnt <= '0;
      level_q  <= ~level_q;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // Strobes lead the level by one cycle so users act on the same clk edge.
  assign sclk_rise = tick && !level_q;
  assign sclk_fall = tick && level_q;

  // Gated so sclk drops as soon as the enable does.
  assign sclk_level = level_q && sclk_en;

endmodule

`default_nettype wire

//--- hw/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::spi_cmd_t  cmd,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               busy,
  output logic               sclk_en,
  input  logic               sclk_level,
  input  logic               sclk_rise,
  input  logic               sclk_fall,
  output spi_pkg::spi_pins_t pins,
  input  logic               miso,
  output logic               rd_vld,
  output spi_pkg::spi_data_t rd_data
);

  import spi_pkg::*;

  typedef enum logic [2:0] {
    idle,
    shift_cmd,
    turnaround,
    shift_in,
    done
  } spi_state_e;

  spi_state_e state;

  logic [CMD_BITS-1:0]                  tx_shreg;
  spi_data_t                            rx_shreg;
  logic [3:0]                           bit_cnt;
  logic [3:0]                           frame_len;
  logic [$clog2(TURNAROUND_CYCLES)-1:0] turn_cnt;
  logic                                 is_read;
  logic                                 cs_n_q;
  logic                                 mosi_q;
  logic                                 sclk_en_q;
  logic                                 last_tx_bit;
  logic                                 last_rx_bit;

  assign last_tx_bit = (bit_cnt == frame_len - 4'd1);
  assign last_rx_bit = (bit_cnt == 4'(DATA_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= idle;
      cs_n_q    <= 1'b1;
      mosi_q    <= 1'b0;
      sclk_en_q <= 1'b0;
      bit_cnt   <= '0;
      frame_len <= '0;
      turn_cnt  <= '0;
      is_read   <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (cmd_vld)
          begin
            // Read sends only op and address before the turnaround.
            is_read   <= (cmd.op == spi_op_read);
            frame_len <= (cmd.op == spi_op_read) ? 4'(ADDR_PHASE_BITS) : 4'(CMD_BITS);
            cs_n_q    <= 1'b0;
            mosi_q    <= cmd.op;
            sclk_en_q <= 1'b1;
            bit_cnt   <= '0;
            state     <= shift_cmd;
          end
        end
        shift_cmd:
        begin
          if (sclk_fall)
          begin
            if (last_tx_bit)
            begin
              cs_n_q    <= 1'b1;
              mosi_q    <= 1'b0;
              sclk_en_q <= 1'b0;
              turn_cnt  <= '0;
              state     <= is_read ? turnaround : done;
            end
            else
            begin
              bit_cnt <= bit_cnt + 4'd1;
              mosi_q  <= tx_shreg[CMD_BITS-2];
            end
          end
        end
        turnaround:
        begin
          if (turn_cnt == ($bits(turn_cnt))'(TURNAROUND_CYCLES - 1))
          begin
            cs_n_q    <= 1'b0;
            sclk_en_q <= 1'b1;
            bit_cnt   <= '0;
            state     <= shift_in;
          end
          else
          begin
            turn_cnt <= turn_cnt + 1'b1;
          end
        end
        shift_in:
        begin
          if (sclk_fall)
          begin
            if (last_rx_bit)
            begin
              cs_n_q    <= 1'b1;
              sclk_en_q <= 1'b0;
              state     <= done;
            end
            else
            begin
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
        end
        done:
        begin
          state <= idle;
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == idle && cmd_vld)
      tx_shreg <= cmd;
    else if (state == shift_cmd && sclk_fall)
      tx_shreg <= {tx_shreg[CMD_BITS-2:0], 1'b0};
    // Mode 0 samples miso on the rising edge.
    if (state == shift_in && sclk_rise)
      rx_shreg <= {rx_shreg[DATA_BITS-2:0], miso};
  end

  assign cmd_rdy = (state == idle);
  assign busy    = (state != idle);
  assign sclk_en = sclk_en_q;
  assign rd_vld  = (state == done) && is_read;
  assign rd_data = rx_shreg;

  assign pins.sclk = sclk_level;
  assign pins.cs_n = cs_n_q;
  assign pins.mosi = mosi_q;

  a_idle_cs_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == idle) |-> pins.cs_n
  );

  // A write must not produce read data before the master is free again.
  a_no_rd_after_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy && cmd.op == spi_op_write) |=> (!rd_vld until cmd_rdy)
  );

endmodule

`default_nettype wire

//--- hw/apb_spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_spi_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  apb_pkg::apb_req_t  apb_req,
  output apb_pkg::apb_rsp_t  apb_rsp,
  output spi_pkg::spi_cmd_t  cmd,
  output logic               cmd_vld,
  input  logic               cmd_rdy,
  input  logic               busy,
  input  logic               rd_vld,
  input  spi_pkg::spi_data_t rd_data,
  output spi_pkg::spi_div_t  div
);

  import spi_pkg::*;
  import apb_pkg::*;

  spi_cmd_t              cmd_q;
  logic                  cmd_vld_q;
  spi_div_t              div_q;
  spi_data_t             rx_data_q;
  logic                  rx_valid_q;
  logic                  access;
  logic                  reg_hit;
  logic                  stall;
  logic                  wr_en;
  logic                  rd_en;
  logic [APB_DATA_W-1:0] rdata;

  assign access = apb_req.psel && apb_req.penable;

  // A second command waits in the access phase until the first is taken.
  assign stall = access && apb_req.pwrite && (apb_req.paddr == REG_CMD) && cmd_vld_q;

  assign wr_en = access && apb_req.pwrite && !stall;
  assign rd_en = access && !apb_req.pwrite;

  always_comb
  begin
    reg_hit = 1'b1;
    rdata   = '0;
    case (apb_req.paddr)
      REG_CMD:    rdata[CMD_BITS-1:0]  = cmd_q;
      REG_STATUS: rdata[1:0]           = {rx_valid_q, busy || cmd_vld_q};
      REG_RXDATA: rdata[DATA_BITS-1:0] = rx_data_q;
      REG_DIV:    rdata[3:0]           = div_q;
      default:    reg_hit              = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_q      <= '0;
      cmd_vld_q  <= 1'b0;
      div_q      <= DIV_RESET;
      rx_valid_q <= 1'b0;
    end
    else
    begin
      if (cmd_vld_q && cmd_rdy)
        cmd_vld_q <= 1'b0;
      if (wr_en && apb_req.paddr == REG_CMD)
      begin
        cmd_q     <= apb_req.pwdata[CMD_BITS-1:0];
        cmd_vld_q <= 1'b1;
      end
      if (wr_en && apb_req.paddr == REG_DIV)
        div_q <= apb_req.pwdata[3:0];
      // New data wins over a read clear in the same cycle.
      if (rd_vld)
        rx_valid_q <= 1'b1;
      else if (rd_en && apb_req.paddr == REG_RXDATA)
        rx_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_vld)
      rx_data_q <= rd_data;
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = !stall;
  assign apb_rsp.pslverr = access && !reg_hit;

  assign cmd     = cmd_q;
  assign cmd_vld = cmd_vld_q;
  assign div     = div_q;

  a_cmd_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cmd_vld && !cmd_rdy) |=> (cmd_vld && $stable(cmd))
  );

endmodule

`default_nettype wire

//--- hw/apb_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module apb_spi_top (
  input  logic               clk,
  input  logic               rst_n,
  input  apb_pkg::apb_req_t  apb_req,
  output apb_pkg::apb_rsp_t  apb_rsp,
  output spi_pkg::spi_pins_t spi_pins,
  input  logic               miso
);

  import spi_pkg::*;

  spi_cmd_t  cmd;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      busy;
  logic      rd_vld;
  spi_data_t rd_data;
  spi_div_t  div;
  logic      sclk_en;
  logic      sclk_level;
  logic      sclk_rise;
  logic      sclk_fall;

  apb_spi_regs i_apb_spi_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .busy    (busy),
    .rd_vld  (rd_vld),
    .rd_data (rd_data),
    .div     (div)
  );

  spi_master i_spi_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .busy       (busy),
    .sclk_en    (sclk_en),
    .sclk_level (sclk_level),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall),
    .pins       (spi_pins),
    .miso       (miso),
    .rd_vld     (rd_vld),
    .rd_data    (rd_data)
  );

  spi_clk_gen i_spi_clk_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk_en    (sclk_en),
    .div        (div),
    .sclk_level (sclk_level),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall)
  );

endmodule

`default_nettype wire

//--- tb/spi_device_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_device_model (
  input  logic               clk,
  input  spi_pkg::spi_pins_t pins,
  output logic               miso
);

  import spi_pkg::*;

  localparam int MAX_FRAMES = 64;

  spi_data_t           regs [0:7];
  logic [CMD_BITS-1:0] frame_bits [0:MAX_FRAMES-1];
  int                  frame_len [0:MAX_FRAMES-1];
  int                  frame_cnt = 0;
  int                  last_gap = 0;
  int                  gap_cnt = 0;
  int                  nbits = 0;
  logic [CMD_BITS-1:0] rx_bits = '0;
  spi_data_t           tx_byte = '0;
  logic                rd_armed = 1'b0;
  spi_addr_t           rd_addr = '0;

  initial
  begin
    miso = 1'b0;
    for (int i = 0; i < 8; i++)
      regs[i] = spi_data_t'(i * 53 + 27);
  end

  // Chip select high time in clk cycles, latched when the next frame starts.
  always @(posedge clk)
  begin
    if (pins.cs_n === 1'b1)
      gap_cnt = gap_cnt + 1;
  end

  always @(negedge pins.cs_n)
  begin
    last_gap = gap_cnt;
    nbits    = 0;
    rx_bits  = '0;
    tx_byte  = rd_armed ? regs[rd_addr] : '0;
    miso     = tx_byte[DATA_BITS-1];
  end

  // Mode 0: sample on the rising edge, shift out on the falling edge.
  always @(posedge pins.sclk)
  begin
    if (!pins.cs_n)
    begin
      rx_bits = {rx_bits[CMD_BITS-2:0], pins.mosi};
      nbits   = nbits + 1;
    end
  end

  always @(negedge pins.sclk)
  begin
    if (!pins.cs_n)
    begin
      tx_byte = {tx_byte[DATA_BITS-2:0], 1'b0};
      miso    = tx_byte[DATA_BITS-1];
    end
  end

  always @(posedge pins.cs_n)
  begin
    gap_cnt = 0;
    if (nbits > 0 && frame_cnt < MAX_FRAMES)
    begin
      frame_bits[frame_cnt] = rx_bits;
      frame_len[frame_cnt]  = nbits;
      frame_cnt             = frame_cnt + 1;
      if (nbits == CMD_BITS && rx_bits[CMD_BITS-1])
        regs[rx_bits[10:8]] = rx_bits[7:0];
      else if (nbits == ADDR_PHASE_BITS && !rx_bits[ADDR_PHASE_BITS-1])
      begin
        rd_armed = 1'b1;
        rd_addr  = rx_bits[2:0];
      end
      else
        rd_armed = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_apb_spi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_apb_spi;

  import spi_pkg::*;
  import apb_pkg::*;

  localparam int CLK_NS         = 8;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MAX_ROWS       = 16;

  localparam apb_rsp_t RSP_OK  = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};
  localparam apb_rsp_t RSP_ERR = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

  typedef struct packed {
    spi_div_t  div;
    spi_op_e   op;
    spi_addr_t addr;
    spi_data_t data;
    spi_data_t exp;
  } row_t;

  logic      clk;
  logic      rst_n;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  spi_pins_t spi_pins;
  logic      miso;

  row_t      rows [0:MAX_ROWS-1];
  int        n_rows = 0;
  spi_data_t shadow [0:7];
  integer    seed = 32'h9336e425;
  string     test_name = "init";
  int        cur_div = DIV_RESET;
  time       t_rise;
  logic      high_seen = 1'b0;

  apb_spi_top i_apb_spi_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .spi_pins (spi_pins),
    .miso     (miso)
  );

  spi_device_model i_model (
    .clk  (clk),
    .pins (spi_pins),
    .miso (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic abort_run();
    begin
      $display("test failed");
      $fatal(1, "Simulation stopped at the first error.");
    end
  endtask

  task automatic check_data(input string what, input spi_data_t exp, input spi_data_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cmd(input string what, input spi_cmd_t exp, input spi_cmd_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_rsp(input string what, input apb_rsp_t exp, input apb_rsp_t act);
    if (act.pslverr !== exp.pslverr)
    begin
      $display("ERROR %s %s pslverr: expected %b, actual %b", test_name, what,
               exp.pslverr, act.pslverr);
      abort_run();
    end
  endtask

  task automatic check_pins(input string what, input spi_pins_t exp, input spi_pins_t act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act !== exp)
    begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // Every sclk high phase lasts DIV+1 clk cycles.
  always @(posedge spi_pins.sclk)
  begin
    t_rise    = $time;
    high_seen = 1'b1;
  end

  always @(negedge spi_pins.sclk)
  begin
    if (high_seen)
    begin
      high_seen = 1'b0;
      check_count("sclk high cycles", cur_div + 1, int'(($time - t_rise) / CLK_NS));
    end
  end

  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output apb_rsp_t rsp, output int waits);
    begin
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = wr;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(posedge clk);
      #1;
      apb_req.penable = 1'b1;
      waits = 0;
      @(negedge clk);
      while (!apb_rsp.pready)
      begin
        waits++;
        if (waits > TIMEOUT_CYCLES)
        begin
          $display("Timeout: APB transfer to offset %h never completed.", addr);
          abort_run();
        end
        @(negedge clk);
      end
      rsp = apb_rsp;
      @(posedge clk);
      #1;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
    end
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] wdata);
    apb_rsp_t rsp;
    int       waits;
    begin
      apb_xfer(1'b1, addr, wdata, rsp, waits);
      check_rsp("write", RSP_OK, rsp);
    end
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] rdata);
    apb_rsp_t rsp;
    int       waits;
    begin
      apb_xfer(1'b0, addr, '0, rsp, waits);
      check_rsp("read", RSP_OK, rsp);
      rdata = rsp.prdata;
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    begin
      polls = 0;
      read_reg(REG_STATUS, st);
      while (st[0])
      begin
        polls++;
        if (polls > TIMEOUT_CYCLES)
        begin
          $display("Timeout: STATUS busy never cleared.");
          abort_run();
        end
        read_reg(REG_STATUS, st);
      end
    end
  endtask

  task automatic wait_frames(input int n);
    int cycles;
    begin
      cycles = 0;
      while (i_model.frame_cnt < n)
      begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
          $display("Timeout: SPI peripheral did not receive frame %0d.", n);
          abort_run();
        end
        @(negedge clk);
      end
    end
  endtask

  task automatic add_row(input spi_div_t div, input spi_op_e op, input spi_addr_t addr);
    row_t r;
    begin
      r.div  = div;
      r.op   = op;
      r.addr = addr;
      r.data = (op == spi_op_write) ? spi_data_t'($random(seed)) : '0;
      if (op == spi_op_write)
        shadow[addr] = r.data;
      r.exp        = shadow[addr];
      rows[n_rows] = r;
      n_rows++;
    end
  endtask

  task automatic build_table();
    begin
      // Same contents the peripheral holds after power up.
      for (int i = 0; i < 8; i++)
        shadow[i] = spi_data_t'(i * 53 + 27);
      add_row(4'd0, spi_op_read, 3'd3);
      add_row(4'd0, spi_op_write, 3'd3);
      add_row(4'd1, spi_op_read, 3'd3);
      add_row(4'd2, spi_op_write, 3'd5);
      add_row(4'd3, spi_op_read, 3'd5);
      add_row(4'd15, spi_op_read, 3'd0);
      add_row(4'd4, spi_op_write, 3'd0);
      add_row(4'd7, spi_op_read, 3'd0);
      add_row(4'd1, spi_op_write, 3'd7);
      add_row(4'd2, spi_op_read, 3'd7);
    end
  endtask

  initial
  begin
    row_t        row;
    spi_cmd_t    cmd_word;
    spi_cmd_t    bp_cmds [0:2];
    apb_rsp_t    rsp;
    logic [31:0] rd;
    int          base;
    int          waits;

    rst_n   = 1'b0;
    apb_req = '0;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_name = "reset";
    check_pins("pins", '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0}, spi_pins);
    read_reg(REG_STATUS, rd);
    check_data("status", 8'h00, rd[7:0]);
    read_reg(REG_DIV, rd);
    check_data("div", spi_data_t'(DIV_RESET), rd[7:0]);

    for (int r = 0; r < n_rows; r++)
    begin
      row       = rows[r];
      test_name = $sformatf("row %0d", r);
      write_reg(REG_DIV, {28'b0, row.div});
      cur_div  = row.div;
      base     = i_model.frame_cnt;
      cmd_word = '{op: row.op, addr: row.addr, data: row.data};
      write_reg(REG_CMD, {20'b0, cmd_word});
      if (row.op == spi_op_write)
      begin
        wait_frames(base + 1);
        wait_idle();
        check_count("frame length", CMD_BITS, i_model.frame_len[base]);
        check_cmd("frame bits", cmd_word, spi_cmd_t'(i_model.frame_bits[base]));
      end
      else
      begin
        wait_frames(base + 2);
        wait_idle();
        check_count("address frame length", ADDR_PHASE_BITS, i_model.frame_len[base]);
        check_data("address frame bits", {5'b0, row.addr}, i_model.frame_bits[base][7:0]);
        check_count("data frame length", DATA_BITS, i_model.frame_len[base + 1]);
        check_count("turnaround cycles", TURNAROUND_CYCLES, i_model.last_gap);
        read_reg(REG_STATUS, rd);
        check_data("status before rxdata", 8'h02, rd[7:0]);
        read_reg(REG_RXDATA, rd);
        check_data("rxdata", row.exp, rd[7:0]);
        read_reg(REG_STATUS, rd);
        check_data("status after rxdata", 8'h00, rd[7:0]);
      end
    end

    // The third write has to wait until the second command leaves the register block.
    test_name = "back-pressure";
    base      = i_model.frame_cnt;
    for (int k = 0; k < 3; k++)
      bp_cmds[k] = '{op: spi_op_write, addr: spi_addr_t'(k * 3 + 1),
                     data: spi_data_t'($random(seed))};
    for (int k = 0; k < 3; k++)
    begin
      apb_xfer(1'b1, REG_CMD, {20'b0, bp_cmds[k]}, rsp, waits);
      check_rsp("command write", RSP_OK, rsp);
      if (k == 1)
        check_count("cs_n after second write", 0, int'(spi_pins.cs_n));
      if (k == 2)
      begin
        if (waits == 0)
        begin
          $display("Third command write was not held back while a command was pending.");
          abort_run();
        end
        check_count("frames at release", base + 1, i_model.frame_cnt);
      end
    end
    wait_frames(base + 3);
    wait_idle();
    for (int k = 0; k < 3; k++)
    begin
      check_count("frame length", CMD_BITS, i_model.frame_len[base + k]);
      check_cmd("frame order", bp_cmds[k], spi_cmd_t'(i_model.frame_bits[base + k]));
    end

    // Offset 0xE shares its upper address bits with REG_DIV.
    test_name = "bad address";
    base      = i_model.frame_cnt;
    apb_xfer(1'b1, 4'hE, 32'hffff_ffff, rsp, waits);
    check_rsp("write", RSP_ERR, rsp);
    apb_xfer(1'b0, 4'hE, '0, rsp, waits);
    check_rsp("read", RSP_ERR, rsp);
    read_reg(REG_DIV, rd);
    check_data("div", spi_data_t'(cur_div), rd[7:0]);
    read_reg(REG_STATUS, rd);
    check_data("status", 8'h00, rd[7:0]);
    read_reg(REG_CMD, rd);
    check_cmd("command register", bp_cmds[2], spi_cmd_t'(rd[CMD_BITS-1:0]));
    check_count("frames", base, i_model.frame_cnt);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/spi_pkg.sv
hw/apb_pkg.sv
hw/spi_clk_gen.sv
hw/spi_master.sv
hw/apb_spi_regs.sv
hw/apb_spi_top.sv
tb/spi_device_model.sv
tb/tb_apb_spi.sv

//--- Bender.yml
package:
  name: apb_spi

sources:
  - hw/spi_pkg.sv
  - hw/apb_pkg.sv
  - hw/spi_clk_gen.sv
  - hw/spi_master.sv
  - hw/apb_spi_regs.sv
  - hw/apb_spi_top.sv
  - target: test
    files:
      - tb/spi_device_model.sv
      - tb/tb_apb_spi.sv
